/* hw/coord_display_pkg.sv */
`default_nettype none

package coord_display_pkg;

    // Input and digit widths
    localparam int COORD_W = 10;
    localparam int DIGIT_W = 4;
    localparam int RGB_W   = 4;

    // 640x480 at 60 Hz, horizontal in pixels
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;

    // Vertical in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;

    localparam int CNT_W = 10;  // Covers 0..799

    // Digit cell geometry
    localparam int CELL_W = 16;
    localparam int CELL_H = 24;
    localparam int STROKE = 3;  // Segment thickness

    // Layout of the 3x3 digit grid
    localparam int COL_X0    = 180;  // Hundreds column
    localparam int COL_PITCH = 30;
    localparam int ROW_Y0    = 100;  // Row of x
    localparam int ROW_PITCH = 80;

    // Seven-segment patterns, bit 6 is segment a down to bit 0 for g
    localparam logic [0:9][6:0] SEG_TABLE = {
        7'b1111110,  // 0
        7'b0110000,  // 1
        7'b1101101,  // 2
        7'b1111001,  // 3
        7'b0110011,  // 4
        7'b1011011,  // 5
        7'b1011111,  // 6
        7'b1110000,  // 7
        7'b1111111,  // 8
        7'b1111011   // 9
    };

endpackage

`default_nettype wire

/* hw/pixel_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_timing #(
    parameter int H_ACTIVE = coord_display_pkg::H_ACTIVE,
    parameter int H_FRONT  = coord_display_pkg::H_FRONT,
    parameter int H_SYNC   = coord_display_pkg::H_SYNC,
    parameter int H_BACK   = coord_display_pkg::H_BACK,
    parameter int V_ACTIVE = coord_display_pkg::V_ACTIVE,
    parameter int V_FRONT  = coord_display_pkg::V_FRONT,
    parameter int V_SYNC   = coord_display_pkg::V_SYNC,
    parameter int V_BACK   = coord_display_pkg::V_BACK
) (
    input  logic                               MAX10_CLK1_50,
    input  logic                               rst_n,
    output logic                               pix_en,
    output logic [coord_display_pkg::CNT_W-1:0] h_count,
    output logic [coord_display_pkg::CNT_W-1:0] v_count,
    output logic                               hsync_raw,
    output logic                               vsync_raw,
    output logic                               frame_start
);

    localparam int CW = coord_display_pkg::CNT_W;

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // Last counter values before wrapping
    localparam logic [CW-1:0] H_LAST = CW'(H_TOTAL - 1);
    localparam logic [CW-1:0] V_LAST = CW'(V_TOTAL - 1);

    // Sync pulse windows, inclusive
    localparam logic [CW-1:0] HS_FIRST = CW'(H_ACTIVE + H_FRONT);
    localparam logic [CW-1:0] HS_LAST  = CW'(H_ACTIVE + H_FRONT + H_SYNC - 1);
    localparam logic [CW-1:0] VS_FIRST = CW'(V_ACTIVE + V_FRONT);
    localparam logic [CW-1:0] VS_LAST  = CW'(V_ACTIVE + V_FRONT + V_SYNC - 1);

    // First blanking line, where the digits get latched
    localparam logic [CW-1:0] V_LATCH = CW'(V_ACTIVE);

    // 25 MHz pixel slot from the 50 MHz clock
    always_ff @(posedge MAX10_CLK1_50) begin
        if (!rst_n) begin
            pix_en <= 1'b0;
        end else begin
            pix_en <= ~pix_en;
        end
    end

    // Raster position
    always_ff @(posedge MAX10_CLK1_50) begin
        if (!rst_n) begin
            h_count <= '0;
            v_count <= '0;
        end else if (pix_en) begin
            if (h_count == H_LAST) begin
                h_count <= '0;
                if (v_count == V_LAST) begin
                    v_count <= '0;
                end else begin
                    v_count <= v_count + 1'b1;
                end
            end else begin
                h_count <= h_count + 1'b1;
            end
        end
    end

    // Both syncs are active low
    always_comb begin
        hsync_raw = !(h_count >= HS_FIRST && h_count <= HS_LAST);
        vsync_raw = !(v_count >= VS_FIRST && v_count <= VS_LAST);
    end

    // One clock wide, on the pix_en clock of the first pixel of line 480
    assign frame_start = pix_en && (h_count == '0) && (v_count == V_LATCH);

endmodule

`default_nettype wire

/* hw/bin_to_bcd.sv */
`timescale 1ns/1ps
`default_nettype none

module bin_to_bcd (
    input  logic                                 MAX10_CLK1_50,
    input  logic                                 rst_n,
    input  logic                                 start,
    input  logic [coord_display_pkg::COORD_W-1:0] value,
    output logic [coord_display_pkg::DIGIT_W-1:0] hundreds,
    output logic [coord_display_pkg::DIGIT_W-1:0] tens,
    output logic [coord_display_pkg::DIGIT_W-1:0] ones
);

    localparam int VW     = coord_display_pkg::COORD_W;
    localparam int DW     = coord_display_pkg::DIGIT_W;
    localparam int BCD_W  = 3 * DW;
    localparam int STEP_W = $clog2(VW);

    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(VW - 1);

    logic [VW-1:0]     bin_q;    // Remaining binary bits, MSB first
    logic [BCD_W-1:0]  bcd_q;    // Partial result, thousands dropped
    logic [BCD_W-1:0]  bcd_adj;
    logic [BCD_W-1:0]  bcd_next;
    logic [STEP_W-1:0] step_cnt;
    logic              busy;

    // Add 3 to every digit of 5 or more, then shift in the next bit
    always_comb begin
        bcd_adj = bcd_q;
        for (int i = 0; i < 3; i++) begin
            if (bcd_q[i*DW +: DW] >= DW'(5)) begin
                bcd_adj[i*DW +: DW] = bcd_q[i*DW +: DW] + DW'(3);
            end
        end
        // Bit leaving the hundreds digit is the thousands carry
        bcd_next = {bcd_adj[BCD_W-2:0], bin_q[VW-1]};
    end

    // Shift registers carry no reset
    always_ff @(posedge MAX10_CLK1_50) begin
        if (start) begin
            bin_q <= value;
            bcd_q <= '0;
        end else if (busy) begin
            bin_q <= {bin_q[VW-2:0], 1'b0};
            bcd_q <= bcd_next;
        end
    end

    always_ff @(posedge MAX10_CLK1_50) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            hundreds <= '0;
            tens     <= '0;
            ones     <= '0;
        end else if (start) begin
            busy     <= 1'b1;
            step_cnt <= '0;
        end else if (busy) begin
            step_cnt <= step_cnt + 1'b1;
            if (step_cnt == LAST_STEP) begin
                busy     <= 1'b0;
                hundreds <= bcd_next[2*DW +: DW];  // All three digits change together
                tens     <= bcd_next[DW +: DW];
                ones     <= bcd_next[0 +: DW];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/digit_renderer.sv */
`timescale 1ns/1ps
`default_nettype none

module digit_renderer #(
    parameter int H_ACTIVE = coord_display_pkg::H_ACTIVE,
    parameter int V_ACTIVE = coord_display_pkg::V_ACTIVE
) (
    input  logic                                 MAX10_CLK1_50,
    input  logic                                 rst_n,
    input  logic                                 pix_en,
    input  logic [coord_display_pkg::CNT_W-1:0]   h_count,
    input  logic [coord_display_pkg::CNT_W-1:0]   v_count,
    input  logic                                 hsync_raw,
    input  logic                                 vsync_raw,
    input  logic [coord_display_pkg::DIGIT_W-1:0] x_hundreds,
    input  logic [coord_display_pkg::DIGIT_W-1:0] x_tens,
    input  logic [coord_display_pkg::DIGIT_W-1:0] x_ones,
    input  logic [coord_display_pkg::DIGIT_W-1:0] y_hundreds,
    input  logic [coord_display_pkg::DIGIT_W-1:0] y_tens,
    input  logic [coord_display_pkg::DIGIT_W-1:0] y_ones,
    input  logic [coord_display_pkg::DIGIT_W-1:0] z_hundreds,
    input  logic [coord_display_pkg::DIGIT_W-1:0] z_tens,
    input  logic [coord_display_pkg::DIGIT_W-1:0] z_ones,
    output logic                                 hsync_out,
    output logic                                 vsync_out,
    output logic [coord_display_pkg::RGB_W-1:0]   VGA_R,
    output logic [coord_display_pkg::RGB_W-1:0]   VGA_G,
    output logic [coord_display_pkg::RGB_W-1:0]   VGA_B
);

    localparam int CW = coord_display_pkg::CNT_W;
    localparam int DW = coord_display_pkg::DIGIT_W;

    localparam int CELL_W = coord_display_pkg::CELL_W;
    localparam int CELL_H = coord_display_pkg::CELL_H;
    localparam int STROKE = coord_display_pkg::STROKE;

    // Top edge of each row and left edge of each column
    localparam logic [CW-1:0] ROW_TOP [3] = '{
        CW'(coord_display_pkg::ROW_Y0),
        CW'(coord_display_pkg::ROW_Y0 + coord_display_pkg::ROW_PITCH),
        CW'(coord_display_pkg::ROW_Y0 + 2 * coord_display_pkg::ROW_PITCH)
    };
    localparam logic [CW-1:0] COL_LEFT [3] = '{
        CW'(coord_display_pkg::COL_X0),
        CW'(coord_display_pkg::COL_X0 + coord_display_pkg::COL_PITCH),
        CW'(coord_display_pkg::COL_X0 + 2 * coord_display_pkg::COL_PITCH)
    };

    // Middle bar spans rows 11 to 13 of the cell
    localparam int G_TOP = CELL_H / 2 - STROKE / 2;

    logic [DW-1:0] cell_digit [3][3];  // [row][column]
    logic          row_hit;
    logic          col_hit;
    logic [1:0]    row_idx;
    logic [1:0]    col_idx;
    logic [CW-1:0] u_off;              // Offset inside the cell
    logic [CW-1:0] w_off;
    logic [DW-1:0] digit;
    logic [6:0]    seg_on;             // Lit segments, a in bit 6
    logic [6:0]    seg_rect;           // Segments covering this pixel
    logic          active;
    logic          lit;

    // Row 0 is x, row 1 is y, row 2 is z
    assign cell_digit[0][0] = x_hundreds;
    assign cell_digit[0][1] = x_tens;
    assign cell_digit[0][2] = x_ones;
    assign cell_digit[1][0] = y_hundreds;
    assign cell_digit[1][1] = y_tens;
    assign cell_digit[1][2] = y_ones;
    assign cell_digit[2][0] = z_hundreds;
    assign cell_digit[2][1] = z_tens;
    assign cell_digit[2][2] = z_ones;

    // Locate the cell, rows and columns do not overlap
    always_comb begin
        row_hit = 1'b0;
        row_idx = '0;
        w_off   = '0;
        col_hit = 1'b0;
        col_idx = '0;
        u_off   = '0;
        for (int r = 0; r < 3; r++) begin
            if (v_count >= ROW_TOP[r] && v_count < ROW_TOP[r] + CW'(CELL_H)) begin
                row_hit = 1'b1;
                row_idx = 2'(r);
                w_off   = v_count - ROW_TOP[r];
            end
        end
        for (int c = 0; c < 3; c++) begin
            if (h_count >= COL_LEFT[c] && h_count < COL_LEFT[c] + CW'(CELL_W)) begin
                col_hit = 1'b1;
                col_idx = 2'(c);
                u_off   = h_count - COL_LEFT[c];
            end
        end
    end

    assign digit  = cell_digit[row_idx][col_idx];
    assign seg_on = (digit <= DW'(9)) ? coord_display_pkg::SEG_TABLE[digit] : 7'b0;

    // Segment rectangles inside the 16x24 cell
    always_comb begin
        seg_rect[6] = w_off < CW'(STROKE);                                        // a
        seg_rect[5] = u_off >= CW'(CELL_W - STROKE) && w_off < CW'(CELL_H / 2);   // b
        seg_rect[4] = u_off >= CW'(CELL_W - STROKE) && w_off >= CW'(CELL_H / 2);  // c
        seg_rect[3] = w_off >= CW'(CELL_H - STROKE);                              // d
        seg_rect[2] = u_off < CW'(STROKE) && w_off >= CW'(CELL_H / 2);            // e
        seg_rect[1] = u_off < CW'(STROKE) && w_off < CW'(CELL_H / 2);             // f
        seg_rect[0] = w_off >= CW'(G_TOP) && w_off < CW'(G_TOP + STROKE);         // g
    end

    assign active = (h_count < CW'(H_ACTIVE)) && (v_count < CW'(V_ACTIVE));
    assign lit    = active && row_hit && col_hit && |(seg_on & seg_rect);

    // Syncs share the colour register stage so they stay aligned
    always_ff @(posedge MAX10_CLK1_50) begin
        if (!rst_n) begin
            hsync_out <= 1'b1;
            vsync_out <= 1'b1;
            VGA_R     <= '0;
            VGA_G     <= '0;
            VGA_B     <= '0;
        end else if (pix_en) begin
            hsync_out <= hsync_raw;
            vsync_out <= vsync_raw;
            VGA_R     <= {coord_display_pkg::RGB_W{lit}};  // White on black
            VGA_G     <= {coord_display_pkg::RGB_W{lit}};
            VGA_B     <= {coord_display_pkg::RGB_W{lit}};
        end
    end

endmodule

`default_nettype wire

/* hw/coord_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module coord_display_top #(
    parameter int H_ACTIVE = coord_display_pkg::H_ACTIVE,
    parameter int H_FRONT  = coord_display_pkg::H_FRONT,
    parameter int H_SYNC   = coord_display_pkg::H_SYNC,
    parameter int H_BACK   = coord_display_pkg::H_BACK,
    parameter int V_ACTIVE = coord_display_pkg::V_ACTIVE,
    parameter int V_FRONT  = coord_display_pkg::V_FRONT,
    parameter int V_SYNC   = coord_display_pkg::V_SYNC,
    parameter int V_BACK   = coord_display_pkg::V_BACK
) (
    input  logic                                 MAX10_CLK1_50,
    input  logic                                 rst_n,
    input  logic [coord_display_pkg::COORD_W-1:0] x_coord,
    input  logic [coord_display_pkg::COORD_W-1:0] y_coord,
    input  logic [coord_display_pkg::COORD_W-1:0] z_coord,
    output logic                                 hsync_out,
    output logic                                 vsync_out,
    output logic [coord_display_pkg::RGB_W-1:0]   VGA_R,
    output logic [coord_display_pkg::RGB_W-1:0]   VGA_G,
    output logic [coord_display_pkg::RGB_W-1:0]   VGA_B
);

    logic                                 pix_en;
    logic [coord_display_pkg::CNT_W-1:0]   h_count;
    logic [coord_display_pkg::CNT_W-1:0]   v_count;
    logic                                 hsync_raw;
    logic                                 vsync_raw;
    logic                                 frame_start;
    logic [coord_display_pkg::DIGIT_W-1:0] x_hundreds, x_tens, x_ones;
    logic [coord_display_pkg::DIGIT_W-1:0] y_hundreds, y_tens, y_ones;
    logic [coord_display_pkg::DIGIT_W-1:0] z_hundreds, z_tens, z_ones;

    pixel_timing #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) u_timing (
        .MAX10_CLK1_50 (MAX10_CLK1_50),
        .rst_n         (rst_n),
        .pix_en        (pix_en),
        .h_count       (h_count),
        .v_count       (v_count),
        .hsync_raw     (hsync_raw),
        .vsync_raw     (vsync_raw),
        .frame_start   (frame_start)
    );

    // One converter per coordinate, all restarted in vertical blanking
    bin_to_bcd u_bcd_x (
        .MAX10_CLK1_50 (MAX10_CLK1_50), .rst_n (rst_n), .start (frame_start),
        .value (x_coord), .hundreds (x_hundreds), .tens (x_tens), .ones (x_ones)
    );

    bin_to_bcd u_bcd_y (
        .MAX10_CLK1_50 (MAX10_CLK1_50), .rst_n (rst_n), .start (frame_start),
        .value (y_coord), .hundreds (y_hundreds), .tens (y_tens), .ones (y_ones)
    );

    bin_to_bcd u_bcd_z (
        .MAX10_CLK1_50 (MAX10_CLK1_50), .rst_n (rst_n), .start (frame_start),
        .value (z_coord), .hundreds (z_hundreds), .tens (z_tens), .ones (z_ones)
    );

    digit_renderer #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) u_renderer (
        .MAX10_CLK1_50 (MAX10_CLK1_50),
        .rst_n         (rst_n),
        .pix_en        (pix_en),
        .h_count       (h_count),
        .v_count       (v_count),
        .hsync_raw     (hsync_raw),
        .vsync_raw     (vsync_raw),
        .x_hundreds    (x_hundreds),
        .x_tens        (x_tens),
        .x_ones        (x_ones),
        .y_hundreds    (y_hundreds),
        .y_tens        (y_tens),
        .y_ones        (y_ones),
        .z_hundreds    (z_hundreds),
        .z_tens        (z_tens),
        .z_ones        (z_ones),
        .hsync_out     (hsync_out),
        .vsync_out     (vsync_out),
        .VGA_R         (VGA_R),
        .VGA_G         (VGA_G),
        .VGA_B         (VGA_B)
    );

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic MAX10_CLK1_50,
    output logic rst_n
);

    initial begin
        MAX10_CLK1_50 = 1'b0;
        forever begin
            #(PERIOD_NS / 2) MAX10_CLK1_50 = ~MAX10_CLK1_50;
        end
    end

    // Released just after an edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge MAX10_CLK1_50);
        #10 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tb/pixel_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_checker (
    input  logic       MAX10_CLK1_50,
    input  logic       rst_n,
    input  logic       hsync_out,
    input  logic       vsync_out,
    input  logic [3:0] VGA_R,
    input  logic [3:0] VGA_G,
    input  logic [3:0] VGA_B,
    input  logic [9:0] x_coord,
    input  logic [9:0] y_coord,
    input  logic [9:0] z_coord,
    output int         sync_errors,
    output int         pixel_errors,
    output int         frames_checked
);

    localparam int H_TOTAL   = 800;
    localparam int H_BACK    = 48;
    localparam int LINE_CLKS = 2 * H_TOTAL;  // Two clocks per pixel slot
    localparam int V_TOTAL   = 525;
    localparam int V_BACK    = 33;

    int   clk_cnt    = 0;
    int   hs_rise_at = -1;
    int   hs_fall_at = -1;
    int   vs_rise_at = -1;
    int   vs_fall_at = -1;
    int   hc         = LINE_CLKS;  // Clocks since the last hsync rise
    int   v_pos      = -1;         // Unknown until the first vsync rise
    int   h_pos;
    int   level;
    bit   armed      = 1'b0;
    logic hs_prev    = 1'b1;
    logic vs_prev    = 1'b1;

    // Inputs are held at zero through the first latch, same as the reset digits
    int shown_x = 0;
    int shown_y = 0;
    int shown_z = 0;

    initial begin
        sync_errors    = 0;
        pixel_errors   = 0;
        frames_checked = 0;
    end

    function automatic bit [6:0] segments_of(input int d);
        case (d)  // a in the MSB, g in the LSB
            0: return 7'b1111110;
            1: return 7'b0110000;
            2: return 7'b1101101;
            3: return 7'b1111001;
            4: return 7'b0110011;
            5: return 7'b1011011;
            6: return 7'b1011111;
            7: return 7'b1110000;
            8: return 7'b1111111;
            9: return 7'b1111011;
            default: return 7'b0000000;
        endcase
    endfunction

    function automatic bit lit_at(input int h, input int v);
        int       row;
        int       col;
        int       u;
        int       w;
        int       value;
        bit [6:0] s;
        row = -1;
        col = -1;
        u   = 0;
        w   = 0;
        for (int r = 0; r < 3; r++) begin
            if (v >= 100 + 80 * r && v < 124 + 80 * r) begin
                row = r;
                w   = v - 100 - 80 * r;
            end
        end
        for (int c = 0; c < 3; c++) begin
            if (h >= 180 + 30 * c && h < 196 + 30 * c) begin
                col = c;
                u   = h - 180 - 30 * c;
            end
        end
        if (row < 0 || col < 0 || h >= 640 || v >= 480) begin
            return 1'b0;
        end
        value = (row == 0) ? shown_x : (row == 1) ? shown_y : shown_z;
        s = segments_of((col == 0) ? value / 100 : (col == 1) ? value / 10 % 10 : value % 10);
        return (s[6] && w <= 2) || (s[5] && u >= 13 && w <= 11) || (s[4] && u >= 13 && w >= 12)
            || (s[3] && w >= 21) || (s[2] && u <= 2 && w >= 12) || (s[1] && u <= 2 && w <= 11)
            || (s[0] && w >= 11 && w <= 13);
    endfunction

    task automatic compare_channel(input string name, input logic [3:0] got, input int exp);
        if (got !== 4'(exp)) begin
            pixel_errors++;
            $display("[ERROR] %0t: %s at (%0d,%0d) expected %0d, got %0d",
                     $time, name, h_pos, v_pos, exp, got);
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            sync_errors++;
            $display("[ERROR] %0t: %s expected %0d, got %0d", $time, name, exp, got);
        end
    endtask

    // Samples are the values from before the edge
    always @(posedge MAX10_CLK1_50) begin
        if (!rst_n) begin
            hs_prev = 1'b1;
            vs_prev = 1'b1;
        end else begin
            clk_cnt++;
            hc++;
            if (!hsync_out && hs_prev) begin
                hs_fall_at = clk_cnt;
            end
            if (hsync_out && !hs_prev) begin
                if (hs_rise_at >= 0) begin
                    compare_count("hsync_out period in clocks", clk_cnt - hs_rise_at, LINE_CLKS);
                end
                if (hs_fall_at >= 0) begin
                    compare_count("hsync_out low time in clocks", clk_cnt - hs_fall_at, 192);
                end
                hs_rise_at = clk_cnt;
                hc = 0;
            end
            if (hc == LINE_CLKS && hs_rise_at >= 0) begin
                sync_errors++;
                $display("hsync_out gave no rising edge for a whole line at %0t", $time);
            end
            if (!vsync_out && vs_prev) begin
                vs_fall_at = clk_cnt;
            end
            if (vsync_out && !vs_prev) begin
                if (vs_rise_at >= 0) begin
                    compare_count("vsync_out period in clocks", clk_cnt - vs_rise_at,
                                  V_TOTAL * LINE_CLKS);
                end
                if (vs_fall_at >= 0) begin
                    compare_count("vsync_out low time in clocks", clk_cnt - vs_fall_at,
                                  2 * LINE_CLKS);
                end
                compare_count("clocks from hsync_out rise to vsync_out rise", hc, 2 * H_BACK);
                vs_rise_at = clk_cnt;
                v_pos = V_TOTAL - V_BACK;  // Line 492
            end else if (hc == 2 * H_BACK && v_pos >= 0) begin
                v_pos = (v_pos + 1) % V_TOTAL;
                if (v_pos == 0) begin
                    armed = 1'b1;
                end
                if (v_pos == 480) begin  // DUT latches here for the next frame
                    frames_checked += armed;
                    armed   = 1'b0;
                    shown_x = x_coord % 1000;
                    shown_y = y_coord % 1000;
                    shown_z = z_coord % 1000;
                end
            end
            if (v_pos >= 0 && hc < LINE_CLKS && hc % 2 == 0) begin
                h_pos = (hc / 2 + H_TOTAL - H_BACK) % H_TOTAL;
                level = lit_at(h_pos, v_pos) ? 15 : 0;
                compare_channel("VGA_R", VGA_R, level);
                compare_channel("VGA_G", VGA_G, level);
                compare_channel("VGA_B", VGA_B, level);
            end
            hs_prev = hsync_out;
            vs_prev = vsync_out;
        end
    end

endmodule

`default_nettype wire

/* tb/coord_display_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module coord_display_tb;

    localparam int WAIT_LIMIT     = 2_000_000;  // Clocks per sync wait
    localparam int RESET_LIMIT    = 100;
    localparam int MAX_LINES      = 32;
    localparam int MID_LINE_RISES = 134;        // hsync rises from line 492 to line 100
    localparam int DRIVE_DELAY    = 10;

    logic       MAX10_CLK1_50;
    logic       rst_n;
    logic [9:0] x_coord;
    logic [9:0] y_coord;
    logic [9:0] z_coord;
    logic       hsync_out;
    logic       vsync_out;
    logic [3:0] VGA_R;
    logic [3:0] VGA_G;
    logic [3:0] VGA_B;

    int sync_errors;
    int pixel_errors;
    int frames_checked;
    int other_errors = 0;
    bit wait_failed  = 1'b0;
    int n_lines      = 0;
    int stim [MAX_LINES][6];  // x y z, then the line 100 replacement
    bit has_mid [MAX_LINES];

    tb_clock_gen #(.PERIOD_NS (100), .RESET_CYCLES (16)) u_clock (
        .MAX10_CLK1_50 (MAX10_CLK1_50),
        .rst_n         (rst_n)
    );

    coord_display_top dut (
        .MAX10_CLK1_50 (MAX10_CLK1_50),
        .rst_n         (rst_n),
        .x_coord       (x_coord),
        .y_coord       (y_coord),
        .z_coord       (z_coord),
        .hsync_out     (hsync_out),
        .vsync_out     (vsync_out),
        .VGA_R         (VGA_R),
        .VGA_G         (VGA_G),
        .VGA_B         (VGA_B)
    );

    pixel_checker u_checker (
        .MAX10_CLK1_50  (MAX10_CLK1_50),
        .rst_n          (rst_n),
        .hsync_out      (hsync_out),
        .vsync_out      (vsync_out),
        .VGA_R          (VGA_R),
        .VGA_G          (VGA_G),
        .VGA_B          (VGA_B),
        .x_coord        (x_coord),
        .y_coord        (y_coord),
        .z_coord        (z_coord),
        .sync_errors    (sync_errors),
        .pixel_errors   (pixel_errors),
        .frames_checked (frames_checked)
    );

    task automatic load_stimulus();
        int                 fd;
        int                 cnt;
        int                 a [6];
        logic [8*128-1:0]   text;
        fd = $fopen("tb/coord_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open tb/coord_input.txt");
            other_errors++;
        end else begin
            while ($fgets(text, fd) != 0 && n_lines < MAX_LINES) begin
                cnt = $sscanf(text, "%d %d %d %d %d %d", a[0], a[1], a[2], a[3], a[4], a[5]);
                if (cnt == 3 || cnt == 6) begin
                    for (int k = 0; k < cnt; k++) begin
                        if (a[k] < 0 || a[k] > 1023) begin
                            $display("Stimulus value %0d does not fit in 10 bits", a[k]);
                            other_errors++;
                        end
                        stim[n_lines][k] = a[k];
                    end
                    has_mid[n_lines] = (cnt == 6);
                    n_lines++;
                end else if (cnt > 0) begin
                    $display("Stimulus line %0d has %0d values, 3 or 6 expected", n_lines, cnt);
                    other_errors++;
                end
            end
            $fclose(fd);
        end
        if (n_lines == 0) begin
            $display("No stimulus lines were read");
            other_errors++;
        end
    endtask

    task automatic wait_for_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < RESET_LIMIT) begin
            @(posedge MAX10_CLK1_50);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was never released");
            other_errors++;
            wait_failed = 1'b1;
        end
    endtask

    task automatic wait_sync_edge(input bit pick_vsync, input bit rising);
        int   n;
        logic prev;
        logic cur;
        n = 0;
        @(posedge MAX10_CLK1_50);
        prev = pick_vsync ? vsync_out : hsync_out;
        cur  = prev;
        while (!(cur == rising && prev != rising) && n < WAIT_LIMIT) begin
            prev = cur;
            @(posedge MAX10_CLK1_50);
            cur = pick_vsync ? vsync_out : hsync_out;
            n++;
        end
        if (!(cur == rising && prev != rising)) begin
            $display("Timed out after %0d clocks waiting for %s to go %s", WAIT_LIMIT,
                     pick_vsync ? "vsync_out" : "hsync_out", rising ? "high" : "low");
            other_errors++;
            wait_failed = 1'b1;
        end
    endtask

    task automatic drive_coords(input int x, input int y, input int z);
        @(posedge MAX10_CLK1_50);
        #DRIVE_DELAY;
        x_coord = 10'(x);
        y_coord = 10'(y);
        z_coord = 10'(z);
    endtask

    initial begin
        int i;
        int k;
        x_coord = '0;
        y_coord = '0;
        z_coord = '0;
        load_stimulus();
        wait_for_reset();
        for (i = 0; i < n_lines && !wait_failed; i++) begin
            wait_sync_edge(1'b1, 1'b0);  // Line 490, after this frame's latch
            if (!wait_failed) begin
                drive_coords(stim[i][0], stim[i][1], stim[i][2]);
            end
            if (!wait_failed && has_mid[i]) begin
                wait_sync_edge(1'b1, 1'b1);
                for (k = 0; k < MID_LINE_RISES && !wait_failed; k++) begin
                    wait_sync_edge(1'b0, 1'b1);
                end
                if (!wait_failed) begin
                    drive_coords(stim[i][3], stim[i][4], stim[i][5]);
                end
            end
        end
        // Last triple needs one frame to latch and one to be shown
        for (k = 0; k < 2 && !wait_failed; k++) begin
            wait_sync_edge(1'b1, 1'b0);
        end
        if (!wait_failed && frames_checked < n_lines + 1) begin
            $display("Only %0d frames were checked, %0d expected", frames_checked, n_lines + 1);
            other_errors++;
        end
        $display("Errors: sync %0d, pixel %0d, other %0d, frames checked %0d",
                 sync_errors, pixel_errors, other_errors, frames_checked);
        if (sync_errors + pixel_errors + other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
hw/coord_display_pkg.sv
hw/pixel_timing.sv
hw/bin_to_bcd.sv
hw/digit_renderer.sv
hw/coord_display_top.sv
tb/tb_clock_gen.sv
tb/pixel_checker.sv
tb/coord_display_tb.sv

/* Bender.yml */
package:
  name: coord_display

sources:
  # Design, package first
  - hw/coord_display_pkg.sv
  - hw/pixel_timing.sv
  - hw/bin_to_bcd.sv
  - hw/digit_renderer.sv
  - hw/coord_display_top.sv

  # Testbench, top module coord_display_tb
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/pixel_checker.sv
      - tb/coord_display_tb.sv

/* tb/coord_input.txt */
# Columns: x y z in decimal, one line per frame, values 0 to 1023
# Optional second x y z replaces the first at line 100, before the latch
7 42 999
1023 1000 512
123 456 789 321 654 987
0 100 888
